//--- src/ex_isa_pkg.sv
package ex_isa_pkg;

    ////////////////////
    // word and field widths
    localparam int WORD_W        = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int ALUOP_W       = 8;
    localparam int ALUSEL_W      = 3;
    localparam int SHAMT_W       = 5;   // low bits of reg1 used as shift amount
    localparam int JUMP_REGION_W = 4;   // upper pc bits kept by j/jal

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////
    // alu operation codes
    localparam logic [ALUOP_W-1:0] OP_NOP    = 8'b0000_0000;
    localparam logic [ALUOP_W-1:0] OP_AND    = 8'b0010_0100;
    localparam logic [ALUOP_W-1:0] OP_OR     = 8'b0010_0101;
    localparam logic [ALUOP_W-1:0] OP_XOR    = 8'b0010_0110;
    localparam logic [ALUOP_W-1:0] OP_NOR    = 8'b0010_0111;
    localparam logic [ALUOP_W-1:0] OP_SLL    = 8'b0111_1100;
    localparam logic [ALUOP_W-1:0] OP_SRL    = 8'b0000_0010;
    localparam logic [ALUOP_W-1:0] OP_SRA    = 8'b0000_0011;
    localparam logic [ALUOP_W-1:0] OP_ADD    = 8'b0010_0000;
    localparam logic [ALUOP_W-1:0] OP_ADDU   = 8'b0010_0001;
    localparam logic [ALUOP_W-1:0] OP_SUB    = 8'b0010_0010;
    localparam logic [ALUOP_W-1:0] OP_SUBU   = 8'b0010_0011;
    localparam logic [ALUOP_W-1:0] OP_SLT    = 8'b0010_1010;
    localparam logic [ALUOP_W-1:0] OP_SLTU   = 8'b0010_1011;
    // traps, immediate forms arrive on reg2
    localparam logic [ALUOP_W-1:0] OP_TGE    = 8'b0011_0000;
    localparam logic [ALUOP_W-1:0] OP_TGEU   = 8'b0011_0001;
    localparam logic [ALUOP_W-1:0] OP_TLT    = 8'b0011_0010;
    localparam logic [ALUOP_W-1:0] OP_TLTU   = 8'b0011_0011;
    localparam logic [ALUOP_W-1:0] OP_TEQ    = 8'b0011_0100;
    localparam logic [ALUOP_W-1:0] OP_TNE    = 8'b0011_0110;
    localparam logic [ALUOP_W-1:0] OP_MOVZ   = 8'b0000_1010;
    localparam logic [ALUOP_W-1:0] OP_MOVN   = 8'b0000_1011;
    localparam logic [ALUOP_W-1:0] OP_JR     = 8'b0000_1000;
    localparam logic [ALUOP_W-1:0] OP_JALR   = 8'b0000_1001;
    localparam logic [ALUOP_W-1:0] OP_J      = 8'b0100_1111;
    localparam logic [ALUOP_W-1:0] OP_JAL    = 8'b0101_0000;
    localparam logic [ALUOP_W-1:0] OP_BEQ    = 8'b0101_0001;
    localparam logic [ALUOP_W-1:0] OP_BNE    = 8'b0101_0010;
    localparam logic [ALUOP_W-1:0] OP_BLEZ   = 8'b0101_0011;
    localparam logic [ALUOP_W-1:0] OP_BGTZ   = 8'b0101_0100;
    localparam logic [ALUOP_W-1:0] OP_BLTZ   = 8'b0100_0000;
    localparam logic [ALUOP_W-1:0] OP_BGEZ   = 8'b0100_0001;
    localparam logic [ALUOP_W-1:0] OP_BLTZAL = 8'b0100_1010;
    localparam logic [ALUOP_W-1:0] OP_BGEZAL = 8'b0100_1011;

    ////////////////////
    // result select codes
    localparam logic [ALUSEL_W-1:0] SEL_NOP         = 3'b000;
    localparam logic [ALUSEL_W-1:0] SEL_LOGIC       = 3'b001;
    localparam logic [ALUSEL_W-1:0] SEL_SHIFT       = 3'b010;
    localparam logic [ALUSEL_W-1:0] SEL_MOVE        = 3'b011;
    localparam logic [ALUSEL_W-1:0] SEL_ARITH       = 3'b100;
    localparam logic [ALUSEL_W-1:0] SEL_JUMP_BRANCH = 3'b110;

endpackage

//--- src/ex_stage_pkg.sv
package ex_stage_pkg;
    import ex_isa_pkg::*;

    // one decoded operation from decode
    typedef struct packed {
        logic [ALUOP_W-1:0]  aluop;
        logic [ALUSEL_W-1:0] alusel;
        word_t               reg1;
        word_t               reg2;
        word_t               imm;    // sign extended, shifted for j/jal
        word_t               pc;
        reg_addr_t           waddr;
        logic                we;
    } ex_req_t;

    typedef struct packed {
        reg_addr_t waddr;
        logic      we;
        word_t     wdata;
    } ex_wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } ex_branch_t;

    typedef struct packed {
        logic trap;
        logic overflow;
    } ex_exc_t;

    ////////////////////
    // unit results into the result mux
    typedef struct packed {
        word_t result;
        logic  overflow;   // add/sub only
        logic  trap;
    } arith_res_t;

    typedef struct packed {
        logic  taken;
        word_t target;
        word_t link;       // pc+8 for linking forms
    } branch_res_t;

endpackage

//--- src/ex_logic_shift.sv
`timescale 1ns/1ps

module ex_logic_shift (
    input  ex_stage_pkg::ex_req_t req_i,
    output ex_isa_pkg::word_t     logic_res_o,
    output ex_isa_pkg::word_t     shift_res_o
);
    import ex_isa_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = req_i.reg1[SHAMT_W-1:0];   // shift amount rides on reg1

    ////////////////////
    // bitwise
    always_comb begin
        case (req_i.aluop)
            OP_OR: begin
                logic_res_o = req_i.reg1 | req_i.reg2;
            end
            OP_AND: begin
                logic_res_o = req_i.reg1 & req_i.reg2;
            end
            OP_NOR: begin
                logic_res_o = ~(req_i.reg1 | req_i.reg2);
            end
            OP_XOR: begin
                logic_res_o = req_i.reg1 ^ req_i.reg2;
            end
            default: begin
                logic_res_o = '0;
            end
        endcase
    end

    ////////////////////
    // shifts, value is reg2
    always_comb begin
        case (req_i.aluop)
            OP_SLL: begin
                shift_res_o = req_i.reg2 << shamt;
            end
            OP_SRL: begin
                shift_res_o = req_i.reg2 >> shamt;
            end
            OP_SRA: begin
                shift_res_o = word_t'($signed(req_i.reg2) >>> shamt);   // sign fill
            end
            default: begin
                shift_res_o = '0;
            end
        endcase
    end

endmodule

//--- src/ex_arith_unit.sv
`timescale 1ns/1ps

module ex_arith_unit (
    input  ex_stage_pkg::ex_req_t    req_i,
    output ex_stage_pkg::arith_res_t arith_o
);
    import ex_isa_pkg::*;

    logic  do_sub;        // reg2 enters inverted, carry in set
    logic  signed_cmp;
    word_t addend;
    word_t sum;
    logic  a_sign;
    logic  b_sign;
    logic  s_sign;
    logic  sum_ovf;
    logic  lt_signed;
    logic  lt_unsigned;
    logic  lt;

    assign do_sub = (req_i.aluop == OP_SUB) || (req_i.aluop == OP_SUBU) ||
                    (req_i.aluop == OP_SLT) || (req_i.aluop == OP_TLT)  ||
                    (req_i.aluop == OP_TGE);

    assign signed_cmp = (req_i.aluop == OP_SLT) || (req_i.aluop == OP_TLT) ||
                        (req_i.aluop == OP_TGE);

    ////////////////////
    // single adder
    assign addend = do_sub ? ~req_i.reg2 : req_i.reg2;
    assign sum    = req_i.reg1 + addend + word_t'(do_sub);

    assign a_sign  = req_i.reg1[WORD_W-1];
    assign b_sign  = addend[WORD_W-1];
    assign s_sign  = sum[WORD_W-1];
    assign sum_ovf = (a_sign == b_sign) && (s_sign != a_sign);   // same-sign inputs, sign flipped

    // signs differ: negative side is smaller, otherwise difference sign decides
    assign lt_signed   = (a_sign && !req_i.reg2[WORD_W-1]) ||
                         ((a_sign == req_i.reg2[WORD_W-1]) && s_sign);
    assign lt_unsigned = req_i.reg1 < req_i.reg2;
    assign lt          = signed_cmp ? lt_signed : lt_unsigned;

    always_comb begin
        case (req_i.aluop)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                arith_o.result = sum;
            end
            OP_SLT, OP_SLTU: begin
                arith_o.result = word_t'(lt);   // 0 or 1
            end
            default: begin
                arith_o.result = '0;
            end
        endcase
    end

    assign arith_o.overflow = sum_ovf && ((req_i.aluop == OP_ADD) || (req_i.aluop == OP_SUB));

    ////////////////////
    // trap conditions
    always_comb begin
        case (req_i.aluop)
            OP_TEQ:          arith_o.trap = (req_i.reg1 == req_i.reg2);
            OP_TNE:          arith_o.trap = (req_i.reg1 != req_i.reg2);
            OP_TGE, OP_TGEU: arith_o.trap = !lt;
            OP_TLT, OP_TLTU: arith_o.trap = lt;
            default:         arith_o.trap = 1'b0;
        endcase
    end

endmodule

//--- src/ex_branch_unit.sv
`timescale 1ns/1ps

module ex_branch_unit (
    input  ex_stage_pkg::ex_req_t     req_i,
    output ex_stage_pkg::branch_res_t branch_o
);
    import ex_isa_pkg::*;

    word_t pc_4;
    word_t pc_8;
    word_t br_target;     // pc-relative target
    word_t jmp_target;    // region jump target
    logic  r1_sign;
    logic  r1_zero;
    logic  r1_eq_r2;

    assign pc_4       = req_i.pc + 4;
    assign pc_8       = req_i.pc + 8;
    assign br_target  = pc_4 + req_i.imm;
    assign jmp_target = {pc_4[WORD_W-1 -: JUMP_REGION_W], req_i.imm[WORD_W-JUMP_REGION_W-1:0]};

    assign r1_sign  = req_i.reg1[WORD_W-1];
    assign r1_zero  = (req_i.reg1 == '0);
    assign r1_eq_r2 = (req_i.reg1 == req_i.reg2);

    ////////////////////
    // direction and target
    always_comb begin
        branch_o.taken  = 1'b0;
        branch_o.target = '0;
        case (req_i.aluop)
            OP_J, OP_JAL: begin
                branch_o.taken  = 1'b1;
                branch_o.target = jmp_target;
            end
            OP_JR, OP_JALR: begin
                branch_o.taken  = 1'b1;
                branch_o.target = req_i.reg1;
            end
            OP_BEQ: begin
                branch_o.taken  = r1_eq_r2;
                branch_o.target = br_target;
            end
            OP_BNE: begin
                branch_o.taken  = !r1_eq_r2;
                branch_o.target = br_target;
            end
            OP_BGTZ: begin
                branch_o.taken  = !r1_sign && !r1_zero;
                branch_o.target = br_target;
            end
            OP_BLEZ: begin
                branch_o.taken  = r1_sign || r1_zero;
                branch_o.target = br_target;
            end
            OP_BGEZ, OP_BGEZAL: begin
                branch_o.taken  = !r1_sign;
                branch_o.target = br_target;
            end
            OP_BLTZ, OP_BLTZAL: begin
                branch_o.taken  = r1_sign;
                branch_o.target = br_target;
            end
            default: begin
            end
        endcase
    end

    // return address, skips the delay slot
    always_comb begin
        case (req_i.aluop)
            OP_JAL, OP_JALR, OP_BGEZAL, OP_BLTZAL: branch_o.link = pc_8;
            default:                               branch_o.link = '0;
        endcase
    end

endmodule

//--- src/ex_result_mux.sv
`timescale 1ns/1ps

module ex_result_mux (
    input  logic                      clk,
    input  logic                      reset_i,
    input  ex_stage_pkg::ex_req_t     req_i,
    input  ex_isa_pkg::word_t         logic_res_i,
    input  ex_isa_pkg::word_t         shift_res_i,
    input  ex_stage_pkg::arith_res_t  arith_i,
    input  ex_stage_pkg::branch_res_t branch_i,
    output ex_stage_pkg::ex_wb_t      wb_o,
    output ex_stage_pkg::ex_branch_t  branch_o,
    output ex_stage_pkg::ex_exc_t     exc_o
);
    import ex_isa_pkg::*;

    word_t wdata_d;
    logic  move_block;    // conditional move not taken
    logic  we_d;

    ////////////////////
    // write data select
    always_comb begin
        case (req_i.alusel)
            SEL_LOGIC: begin
                wdata_d = logic_res_i;
            end
            SEL_SHIFT: begin
                wdata_d = shift_res_i;
            end
            SEL_ARITH: begin
                wdata_d = arith_i.result;
            end
            SEL_MOVE: begin
                wdata_d = req_i.reg1;
            end
            SEL_JUMP_BRANCH: begin
                wdata_d = branch_i.link;
            end
            default: begin
                wdata_d = '0;
            end
        endcase
    end

    always_comb begin
        case (req_i.aluop)
            OP_MOVZ: move_block = (req_i.reg2 != '0);
            OP_MOVN: move_block = (req_i.reg2 == '0);
            default: move_block = 1'b0;
        endcase
    end

    // overflowed add/sub must not reach the register file
    assign we_d = req_i.we && !arith_i.overflow && !move_block;

    ////////////////////
    // stage output latch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o     <= '0;
            branch_o <= '0;
            exc_o    <= '0;
        end else begin
            wb_o.waddr      <= req_i.waddr;
            wb_o.we         <= we_d;
            wb_o.wdata      <= wdata_d;
            branch_o.taken  <= branch_i.taken;
            branch_o.target <= branch_i.target;
            exc_o.trap      <= arith_i.trap;
            exc_o.overflow  <= arith_i.overflow;
        end
    end

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                     clk,
    input  logic                     reset_i,
    input  ex_stage_pkg::ex_req_t    req_i,
    output ex_stage_pkg::ex_wb_t     wb_o,
    output ex_stage_pkg::ex_branch_t branch_o,
    output ex_stage_pkg::ex_exc_t    exc_o
);
    import ex_isa_pkg::*;
    import ex_stage_pkg::*;

    word_t       logic_res;
    word_t       shift_res;
    arith_res_t  arith_res;
    branch_res_t branch_res;

    ////////////////////
    // combinational units
    ex_logic_shift u_logic_shift (
        .req_i       (req_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res)
    );

    ex_arith_unit u_arith_unit (
        .req_i   (req_i),
        .arith_o (arith_res)
    );

    ex_branch_unit u_branch_unit (
        .req_i    (req_i),
        .branch_o (branch_res)
    );

    // select and register, one cycle
    ex_result_mux u_result_mux (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .logic_res_i (logic_res),
        .shift_res_i (shift_res),
        .arith_i     (arith_res),
        .branch_i    (branch_res),
        .wb_o        (wb_o),
        .branch_o    (branch_o),
        .exc_o       (exc_o)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // sync reset, released on the edge after the last reset cycle
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_isa_pkg::*;
    import ex_stage_pkg::*;

    // about 140 cycles of tests plus reset
    localparam int TEST_CYCLES = 150;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic       clk;
    logic       reset_i;
    ex_req_t    req;
    ex_wb_t     wb;
    ex_branch_t br;
    ex_exc_t    exc;

    word_t   lfsr_state  = 32'd83222;
    int      error_count = 0;
    int      check_count = 0;
    int      cycle_count = 0;
    ex_req_t prev_req;              // op whose result is due next
    logic    have_prev   = 1'b0;

    tb_clock_gen i_clock_gen (.clk_o(clk), .reset_o(reset_i));

    ex_stage i_dut (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (req),
        .wb_o     (wb),
        .branch_o (br),
        .exc_o    (exc)
    );

    ////////////////////
    // random operands
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'hD000_0001;   // x^32+x^31+x^29+x+1
        end
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[WORD_W-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic ex_req_t make_req(input logic [ALUOP_W-1:0] op,
                                         input logic [ALUSEL_W-1:0] sel,
                                         input word_t a, input word_t b, input logic we);
        ex_req_t r;
        word_t   pc_raw;
        pc_raw   = rand_bits(WORD_W);
        r.aluop  = op;
        r.alusel = sel;
        r.reg1   = a;
        r.reg2   = b;
        r.imm    = rand_bits(WORD_W);
        r.pc     = {pc_raw[WORD_W-1:2], 2'b00};   // word aligned
        r.waddr  = reg_addr_t'(rand_bits(REG_ADDR_W));
        r.we     = we;
        return r;
    endfunction

    ////////////////////
    // reference model
    function automatic void model_ex(input ex_req_t r, output ex_wb_t wb_e,
                                     output ex_branch_t br_e, output ex_exc_t exc_e);
        logic [SHAMT_W-1:0]  sh;
        logic [2*WORD_W-1:0] ext;
        longint              wide;
        word_t               logic_v;
        word_t               shift_v;
        word_t               arith_v;
        word_t               link;
        word_t               pc4;
        logic                ovf;
        sh      = r.reg1[SHAMT_W-1:0];
        ext     = {{WORD_W{r.reg2[WORD_W-1]}}, r.reg2};   // sign extended for sra
        pc4     = r.pc + 4;
        logic_v = '0;
        shift_v = '0;
        arith_v = '0;
        ovf     = 1'b0;
        wide    = 0;
        br_e    = '0;
        exc_e   = '0;
        case (r.aluop)
            OP_OR:   logic_v = r.reg1 | r.reg2;
            OP_AND:  logic_v = r.reg1 & r.reg2;
            OP_NOR:  logic_v = ~(r.reg1 | r.reg2);
            OP_XOR:  logic_v = r.reg1 ^ r.reg2;
            OP_SLL:  shift_v = r.reg2 << sh;
            OP_SRL:  shift_v = r.reg2 >> sh;
            OP_SRA:  shift_v = word_t'(ext >> sh);
            OP_ADD:  wide = longint'($signed(r.reg1)) + longint'($signed(r.reg2));
            OP_SUB:  wide = longint'($signed(r.reg1)) - longint'($signed(r.reg2));
            OP_ADDU: arith_v = r.reg1 + r.reg2;
            OP_SUBU: arith_v = r.reg1 - r.reg2;
            OP_SLT:  arith_v = word_t'($signed(r.reg1) < $signed(r.reg2));
            OP_SLTU: arith_v = word_t'(r.reg1 < r.reg2);
            OP_TEQ:  exc_e.trap = (r.reg1 == r.reg2);
            OP_TNE:  exc_e.trap = (r.reg1 != r.reg2);
            OP_TGE:  exc_e.trap = ($signed(r.reg1) >= $signed(r.reg2));
            OP_TGEU: exc_e.trap = (r.reg1 >= r.reg2);
            OP_TLT:  exc_e.trap = ($signed(r.reg1) < $signed(r.reg2));
            OP_TLTU: exc_e.trap = (r.reg1 < r.reg2);
            OP_J, OP_JAL: begin
                br_e.taken  = 1'b1;
                br_e.target = {pc4[WORD_W-1 -: JUMP_REGION_W],
                               r.imm[WORD_W-JUMP_REGION_W-1:0]};
            end
            OP_JR, OP_JALR: begin
                br_e.taken  = 1'b1;
                br_e.target = r.reg1;
            end
            OP_BEQ:             br_e.taken = (r.reg1 == r.reg2);
            OP_BNE:             br_e.taken = (r.reg1 != r.reg2);
            OP_BGTZ:            br_e.taken = ($signed(r.reg1) > 0);
            OP_BLEZ:            br_e.taken = ($signed(r.reg1) <= 0);
            OP_BGEZ, OP_BGEZAL: br_e.taken = ($signed(r.reg1) >= 0);
            OP_BLTZ, OP_BLTZAL: br_e.taken = ($signed(r.reg1) < 0);
            default: ;
        endcase
        if (r.aluop == OP_ADD || r.aluop == OP_SUB) begin
            arith_v = word_t'(wide);
            ovf     = !((wide[63:31] == '0) || (wide[63:31] == '1));   // no 32-bit fit
        end
        case (r.aluop)
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
            OP_BGEZ, OP_BGEZAL, OP_BLTZ, OP_BLTZAL: br_e.target = pc4 + r.imm;
            default: ;
        endcase
        case (r.aluop)
            OP_JAL, OP_JALR, OP_BGEZAL, OP_BLTZAL: link = r.pc + 8;
            default:                               link = '0;
        endcase
        exc_e.overflow = ovf;
        wb_e.waddr     = r.waddr;
        wb_e.we        = r.we && !ovf;
        if ((r.aluop == OP_MOVZ && r.reg2 != '0) || (r.aluop == OP_MOVN && r.reg2 == '0)) begin
            wb_e.we = 1'b0;   // move condition not met
        end
        case (r.alusel)
            SEL_LOGIC:       wb_e.wdata = logic_v;
            SEL_SHIFT:       wb_e.wdata = shift_v;
            SEL_ARITH:       wb_e.wdata = arith_v;
            SEL_MOVE:        wb_e.wdata = r.reg1;
            SEL_JUMP_BRANCH: wb_e.wdata = link;
            default:         wb_e.wdata = '0;
        endcase
    endfunction

    ////////////////////
    // checking
    task automatic check_value(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: %s = %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs(input ex_req_t r);
        ex_wb_t     wb_e;
        ex_branch_t br_e;
        ex_exc_t    exc_e;
        string      tag;
        model_ex(r, wb_e, br_e, exc_e);
        tag = $sformatf("op %h sel %0d", r.aluop, r.alusel);
        check_value({tag, " waddr"}, word_t'(wb.waddr), word_t'(wb_e.waddr));
        check_value({tag, " we"}, word_t'(wb.we), word_t'(wb_e.we));
        check_value({tag, " wdata"}, wb.wdata, wb_e.wdata);
        check_value({tag, " taken"}, word_t'(br.taken), word_t'(br_e.taken));
        check_value({tag, " target"}, br.target, br_e.target);
        check_value({tag, " trap"}, word_t'(exc.trap), word_t'(exc_e.trap));
        check_value({tag, " overflow"}, word_t'(exc.overflow), word_t'(exc_e.overflow));
    endtask

    // one request per edge with the previous result checked mid cycle
    task automatic send(input ex_req_t r);
        @(posedge clk);
        req <= r;
        @(negedge clk);
        if (have_prev) begin
            check_outputs(prev_req);
        end
        prev_req  = r;
        have_prev = 1'b1;
    endtask

    task automatic flush();
        send('0);
        have_prev = 1'b0;
    endtask

    ////////////////////
    // directed tests
    task automatic test_reset();
        ex_req_t stim [4];
        stim[0] = make_req(OP_JAL, SEL_JUMP_BRANCH, '0, '0, 1'b1);   // we, taken and link
        stim[1] = make_req(OP_TEQ, SEL_NOP, 32'd5, 32'd5, 1'b0);
        stim[2] = make_req(OP_ADD, SEL_ARITH, 32'h7FFF_FFFF, 32'h0000_0001, 1'b1);
        stim[3] = '0;
        foreach (stim[i]) begin
            @(posedge clk);
            req <= stim[i];
            if (i > 0) begin
                // result of the request taken on this edge, still in reset
                @(negedge clk);
                check_value("reset waddr", word_t'(wb.waddr), '0);
                check_value("reset we", word_t'(wb.we), '0);
                check_value("reset wdata", wb.wdata, '0);
                check_value("reset taken", word_t'(br.taken), '0);
                check_value("reset target", br.target, '0);
                check_value("reset trap", word_t'(exc.trap), '0);
                check_value("reset overflow", word_t'(exc.overflow), '0);
            end
        end
        wait (!reset_i);
    endtask

    task automatic test_logic_shift();
        logic [ALUOP_W-1:0] ops [7] = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
        word_t a;
        word_t b;
        for (int i = 0; i < 4; i++) begin
            a = rand_bits(WORD_W);
            b = rand_bits(WORD_W);
            foreach (ops[k]) begin
                send(make_req(ops[k], (k < 4) ? SEL_LOGIC : SEL_SHIFT, a, b, i[0]));
            end
        end
        for (int i = 0; i < 4; i++) begin
            b = rand_bits(WORD_W) | 32'h8000_0000;   // negative value for sign fill
            send(make_req(OP_SRA, SEL_SHIFT, rand_bits(WORD_W), b, 1'b1));
        end
        flush();
    endtask

    task automatic test_arith();
        logic [ALUOP_W-1:0] ops [4] = '{OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU};
        word_t a;
        word_t b;
        for (int i = 0; i < 4; i++) begin
            a = rand_bits(WORD_W);
            b = rand_bits(WORD_W);
            if (i == 1) begin
                a = a | 32'h8000_0000;   // signed and unsigned order disagree
                b = b & 32'h7FFF_FFFF;
            end
            foreach (ops[k]) begin
                send(make_req(ops[k], SEL_ARITH, a, b, 1'b1));
            end
        end
        send(make_req(OP_ADD, SEL_ARITH, 32'h7FFF_FFFF, 32'h0000_0001, 1'b1));
        send(make_req(OP_ADD, SEL_ARITH, 32'h8000_0000, 32'h8000_0000, 1'b1));
        send(make_req(OP_SUB, SEL_ARITH, 32'h8000_0000, 32'h0000_0001, 1'b1));
        send(make_req(OP_SUB, SEL_ARITH, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 1'b1));
        send(make_req(OP_ADDU, SEL_ARITH, 32'h7FFF_FFFF, 32'h0000_0001, 1'b1));
        send(make_req(OP_ADD, SEL_ARITH, 32'h0000_0005, 32'h0000_0003, 1'b1));
        flush();
    endtask

    task automatic test_traps();
        logic [ALUOP_W-1:0] ops [6] = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
        word_t pa [6] = '{32'd5, 32'd7, 32'd3, 32'hFFFF_FFFF, 32'd1, 32'h8000_0000};
        word_t pb [6] = '{32'd5, 32'd3, 32'd7, 32'd1, 32'hFFFF_FFFF, 32'h8000_0000};
        foreach (pa[p]) begin
            foreach (ops[k]) begin
                send(make_req(ops[k], SEL_NOP, pa[p], pb[p], 1'b0));
            end
        end
        flush();
    endtask

    task automatic test_moves_jumps();
        word_t a;
        word_t nz;
        a  = rand_bits(WORD_W);
        nz = rand_bits(WORD_W) | 32'h1;
        send(make_req(OP_MOVZ, SEL_MOVE, a, '0, 1'b1));
        send(make_req(OP_MOVZ, SEL_MOVE, a, nz, 1'b1));
        send(make_req(OP_MOVN, SEL_MOVE, a, nz, 1'b1));
        send(make_req(OP_MOVN, SEL_MOVE, a, '0, 1'b1));
        send(make_req(OP_J, SEL_JUMP_BRANCH, a, nz, 1'b0));
        send(make_req(OP_JAL, SEL_JUMP_BRANCH, a, nz, 1'b1));
        send(make_req(OP_JR, SEL_JUMP_BRANCH, rand_bits(WORD_W), nz, 1'b0));
        send(make_req(OP_JALR, SEL_JUMP_BRANCH, rand_bits(WORD_W), nz, 1'b1));
        flush();
    endtask

    task automatic test_branches();
        logic [ALUOP_W-1:0] ops [8] = '{OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
                                       OP_BGEZ, OP_BLTZ, OP_BGEZAL, OP_BLTZAL};
        word_t r1 [3];
        logic  link;
        r1[0] = (rand_bits(WORD_W) & 32'h7FFF_FFFF) | 32'h1;
        r1[1] = '0;
        r1[2] = rand_bits(WORD_W) | 32'h8000_0000;
        foreach (r1[v]) begin
            foreach (ops[k]) begin
                link = (ops[k] == OP_BGEZAL) || (ops[k] == OP_BLTZAL);
                if (ops[k] == OP_BEQ || ops[k] == OP_BNE) begin
                    send(make_req(ops[k], SEL_JUMP_BRANCH, r1[v], r1[v], 1'b0));
                    send(make_req(ops[k], SEL_JUMP_BRANCH, r1[v], r1[v] ^ 32'h100, 1'b0));
                end else begin
                    send(make_req(ops[k], SEL_JUMP_BRANCH, r1[v], rand_bits(WORD_W), link));
                end
            end
        end
        flush();
    endtask

    initial begin
        req = '0;
        test_reset();
        test_logic_shift();
        test_arith();
        test_traps();
        test_moves_jumps();
        test_branches();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

//--- project.f
src/ex_isa_pkg.sv
src/ex_stage_pkg.sv
src/ex_logic_shift.sv
src/ex_arith_unit.sv
src/ex_branch_unit.sv
src/ex_result_mux.sv
src/ex_stage.sv
test/tb_clock_gen.sv
test/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module tb_ex_stage -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_ex_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    echo "result: passed"
    exit 0
else
    echo "result: failed"
    exit 1
fi
